// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // geometry
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = 4;
  localparam int WAY_CNT    = 2;
  localparam int SET_CNT    = 16;
  localparam int LINE_WORDS = 4;

  // address split into tag, index, word and byte
  localparam int OFS_W  = $clog2(STRB_W);
  localparam int WORD_W = $clog2(LINE_WORDS);
  localparam int IDX_W  = $clog2(SET_CNT);
  localparam int TAG_W  = ADDR_W - IDX_W - WORD_W - OFS_W;

  typedef logic [$clog2(WAY_CNT)-1:0] way_sel_t;
  typedef logic [IDX_W-1:0]           idx_t;
  typedef logic [TAG_W-1:0]           tag_t;
  typedef logic [WORD_W-1:0]          word_sel_t;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    WB_ADR  = 3'd1,
    WB_DAT  = 3'd2,
    RF_ADR  = 3'd3,
    RF_DAT  = 3'd4,
    TAG_UPD = 3'd5
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== source/cache_way.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_way (
  input  logic                        clk,
  input  logic                        rst_n,
  // access port
  input  cache_pkg::idx_t             acc_idx_i,
  input  cache_pkg::word_sel_t        acc_word_i,
  input  logic                        acc_we_i,
  input  logic [cache_pkg::DATA_W-1:0] acc_wdata_i,
  input  logic [cache_pkg::STRB_W-1:0] acc_strb_i,
  output cache_pkg::tag_t             acc_tag_o,
  output logic                        acc_valid_o,
  output logic [cache_pkg::DATA_W-1:0] acc_rdata_o,
  // line port
  input  cache_pkg::idx_t             ln_idx_i,
  input  cache_pkg::word_sel_t        ln_word_i,
  input  logic                        ln_fill_we_i,
  input  logic [cache_pkg::DATA_W-1:0] ln_fill_data_i,
  input  logic                        ln_tag_we_i,
  input  cache_pkg::tag_t             ln_tag_i,
  output cache_pkg::tag_t             ln_tag_o,
  output logic                        ln_valid_o,
  output logic                        ln_dirty_o,
  output logic [cache_pkg::DATA_W-1:0] ln_rdata_o
);

  cache_pkg::tag_t              tag_q   [cache_pkg::SET_CNT];
  logic [cache_pkg::SET_CNT-1:0] valid_q;
  logic [cache_pkg::SET_CNT-1:0] dirty_q;
  logic [cache_pkg::DATA_W-1:0]  data_q  [cache_pkg::SET_CNT][cache_pkg::LINE_WORDS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (ln_tag_we_i) begin
      valid_q[ln_idx_i] <= 1'b1;
      dirty_q[ln_idx_i] <= 1'b0;
    end else if (acc_we_i) begin
      dirty_q[acc_idx_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ln_tag_we_i) begin
      tag_q[ln_idx_i] <= ln_tag_i;
    end
    if (ln_fill_we_i) begin
      data_q[ln_idx_i][ln_word_i] <= ln_fill_data_i;
    end
    // byte merge on hit writes
    if (acc_we_i) begin
      for (int b = 0; b < cache_pkg::STRB_W; b++) begin
        if (acc_strb_i[b]) begin
          data_q[acc_idx_i][acc_word_i][8*b +: 8] <= acc_wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign acc_tag_o   = tag_q[acc_idx_i];
  assign acc_valid_o = valid_q[acc_idx_i];
  assign acc_rdata_o = data_q[acc_idx_i][acc_word_i];

  assign ln_tag_o    = tag_q[ln_idx_i];
  assign ln_valid_o  = valid_q[ln_idx_i];
  assign ln_dirty_o  = dirty_q[ln_idx_i];
  assign ln_rdata_o  = data_q[ln_idx_i][ln_word_i];

endmodule

`default_nettype wire

// ==== source/hit_access.sv ====
`timescale 1ns/10ps
`default_nettype none

module hit_access (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             cpu_valid_i,
  input  logic                                             cpu_we_i,
  input  logic [cache_pkg::ADDR_W-1:0]                      cpu_addr_i,
  input  logic [cache_pkg::DATA_W-1:0]                      cpu_wdata_i,
  input  logic [cache_pkg::STRB_W-1:0]                      cpu_strb_i,
  output logic                                             cpu_ready_o,
  output logic                                             resp_valid_o,
  output logic [cache_pkg::DATA_W-1:0]                      resp_rdata_o,
  // way side
  input  cache_pkg::tag_t [cache_pkg::WAY_CNT-1:0]          way_tag_i,
  input  logic [cache_pkg::WAY_CNT-1:0]                     way_valid_i,
  input  logic [cache_pkg::WAY_CNT-1:0][cache_pkg::DATA_W-1:0] way_rdata_i,
  output cache_pkg::idx_t                                  acc_idx_o,
  output cache_pkg::word_sel_t                             acc_word_o,
  output logic [cache_pkg::WAY_CNT-1:0]                     acc_we_o,
  output logic [cache_pkg::DATA_W-1:0]                      acc_wdata_o,
  output logic [cache_pkg::STRB_W-1:0]                      acc_strb_o,
  // refill side
  output logic                                             miss_req_o,
  output cache_pkg::idx_t                                  miss_idx_o,
  output cache_pkg::tag_t                                  miss_tag_o,
  input  logic                                             fill_done_i
);

  localparam int IDX_LSB = cache_pkg::OFS_W + cache_pkg::WORD_W;

  logic                         held_q;
  logic                         miss_q;
  logic                         resp_valid_q;
  logic [cache_pkg::DATA_W-1:0] resp_rdata_q;
  logic                         req_we_q;
  cache_pkg::tag_t              req_tag_q;
  cache_pkg::idx_t              req_idx_q;
  cache_pkg::word_sel_t         req_word_q;
  logic [cache_pkg::DATA_W-1:0] req_wdata_q;
  logic [cache_pkg::STRB_W-1:0] req_strb_q;

  logic                          accept;
  logic                          lookup;
  logic [cache_pkg::WAY_CNT-1:0] hit_way;
  logic                          hit_any;
  logic [cache_pkg::DATA_W-1:0]  hit_rdata;

  assign cpu_ready_o = !held_q;
  assign accept      = cpu_valid_i && cpu_ready_o;
  // no lookup while a refill is pending
  assign lookup      = held_q && !miss_q;

  always_comb begin
    hit_rdata = '0;
    for (int w = 0; w < cache_pkg::WAY_CNT; w++) begin
      hit_way[w] = way_valid_i[w] && (way_tag_i[w] == req_tag_q);
      if (hit_way[w]) begin
        hit_rdata = hit_rdata | way_rdata_i[w];
      end
    end
  end

  assign hit_any = |hit_way;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      held_q       <= 1'b0;
      miss_q       <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= 1'b0;
      if (accept) begin
        held_q <= 1'b1;
      end else if (lookup && hit_any) begin
        held_q       <= 1'b0;
        resp_valid_q <= 1'b1;
      end
      if (lookup && !hit_any) begin
        miss_q <= 1'b1;
      end else if (fill_done_i) begin
        miss_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_we_q    <= cpu_we_i;
      req_tag_q   <= cpu_addr_i[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
      req_idx_q   <= cpu_addr_i[IDX_LSB +: cache_pkg::IDX_W];
      req_word_q  <= cpu_addr_i[cache_pkg::OFS_W +: cache_pkg::WORD_W];
      req_wdata_q <= cpu_wdata_i;
      req_strb_q  <= cpu_strb_i;
    end
    if (lookup) begin
      resp_rdata_q <= hit_rdata;
    end
  end

  assign acc_idx_o   = req_idx_q;
  assign acc_word_o  = req_word_q;
  assign acc_wdata_o = req_wdata_q;
  assign acc_strb_o  = req_strb_q;
  assign acc_we_o    = (lookup && req_we_q) ? hit_way : '0;

  assign resp_valid_o = resp_valid_q;
  assign resp_rdata_o = resp_rdata_q;

  assign miss_req_o = miss_q;
  assign miss_idx_o = req_idx_q;
  assign miss_tag_o = req_tag_q;

endmodule

`default_nettype wire

// ==== source/line_refill_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_refill_ctrl (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             miss_req_i,
  input  cache_pkg::idx_t                                  miss_idx_i,
  input  cache_pkg::tag_t                                  miss_tag_i,
  output logic                                             fill_done_o,
  // way side
  output cache_pkg::idx_t                                  ln_idx_o,
  output cache_pkg::word_sel_t                             ln_word_o,
  output logic [cache_pkg::WAY_CNT-1:0]                     ln_fill_we_o,
  output logic [cache_pkg::DATA_W-1:0]                      ln_fill_data_o,
  output logic [cache_pkg::WAY_CNT-1:0]                     ln_tag_we_o,
  output cache_pkg::tag_t                                  ln_tag_o,
  input  cache_pkg::tag_t [cache_pkg::WAY_CNT-1:0]          way_tag_i,
  input  logic [cache_pkg::WAY_CNT-1:0]                     way_valid_i,
  input  logic [cache_pkg::WAY_CNT-1:0]                     way_dirty_i,
  input  logic [cache_pkg::WAY_CNT-1:0][cache_pkg::DATA_W-1:0] way_rdata_i,
  // bus side
  output logic                                             bus_avalid_o,
  output logic                                             bus_awrite_o,
  output logic [cache_pkg::ADDR_W-1:0]                      bus_addr_o,
  input  logic                                             bus_aready_i,
  output logic                                             bus_wvalid_o,
  output logic [cache_pkg::DATA_W-1:0]                      bus_wdata_o,
  output logic                                             bus_wlast_o,
  input  logic                                             bus_wready_i,
  input  logic                                             bus_rvalid_i,
  input  logic [cache_pkg::DATA_W-1:0]                      bus_rdata_i,
  input  logic                                             bus_rlast_i
);

  localparam int LINE_OFS_W = cache_pkg::WORD_W + cache_pkg::OFS_W;

  cache_pkg::ctrl_state_t state_q;
  cache_pkg::way_sel_t    victim_q;
  cache_pkg::way_sel_t    victim_next;
  cache_pkg::word_sel_t   beat_q;
  logic                   last_beat;
  logic                   victim_dirty;

  logic [cache_pkg::ADDR_W-1:0] wb_addr;
  logic [cache_pkg::ADDR_W-1:0] rf_addr;

  // rotating replacement names the stepped value as victim
  assign victim_next  = victim_q + 1'b1;
  assign victim_dirty = way_valid_i[victim_next] && way_dirty_i[victim_next];
  assign last_beat    = (beat_q == cache_pkg::word_sel_t'(cache_pkg::LINE_WORDS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= cache_pkg::IDLE;
      victim_q <= '0;
      beat_q   <= '0;
    end else begin
      case (state_q)
        cache_pkg::IDLE: begin
          beat_q <= '0;
          if (miss_req_i) begin
            victim_q <= victim_next;
            if (victim_dirty) begin
              state_q <= cache_pkg::WB_ADR;
            end else begin
              state_q <= cache_pkg::RF_ADR;
            end
          end
        end
        cache_pkg::WB_ADR: begin
          if (bus_aready_i) begin
            state_q <= cache_pkg::WB_DAT;
          end
        end
        cache_pkg::WB_DAT: begin
          if (bus_wready_i) begin
            beat_q <= beat_q + 1'b1;
            if (last_beat) begin
              state_q <= cache_pkg::RF_ADR;
            end
          end
        end
        cache_pkg::RF_ADR: begin
          if (bus_aready_i) begin
            state_q <= cache_pkg::RF_DAT;
          end
        end
        cache_pkg::RF_DAT: begin
          // beats only advance on rvalid
          if (bus_rvalid_i) begin
            beat_q <= beat_q + 1'b1;
            if (bus_rlast_i) begin
              state_q <= cache_pkg::TAG_UPD;
            end
          end
        end
        default: begin
          state_q <= cache_pkg::IDLE;
        end
      endcase
    end
  end

  // old tag stays put in the way until TAG_UPD
  assign wb_addr = {way_tag_i[victim_q], miss_idx_i, {LINE_OFS_W{1'b0}}};
  assign rf_addr = {miss_tag_i, miss_idx_i, {LINE_OFS_W{1'b0}}};

  assign bus_avalid_o = (state_q == cache_pkg::WB_ADR) || (state_q == cache_pkg::RF_ADR);
  assign bus_awrite_o = (state_q == cache_pkg::WB_ADR);
  assign bus_addr_o   = (state_q == cache_pkg::WB_ADR) ? wb_addr : rf_addr;

  assign bus_wvalid_o = (state_q == cache_pkg::WB_DAT);
  assign bus_wdata_o  = way_rdata_i[victim_q];
  assign bus_wlast_o  = (state_q == cache_pkg::WB_DAT) && last_beat;

  assign ln_idx_o       = miss_idx_i;
  assign ln_word_o      = beat_q;
  assign ln_fill_data_o = bus_rdata_i;
  assign ln_tag_o       = miss_tag_i;

  always_comb begin
    ln_fill_we_o = '0;
    ln_tag_we_o  = '0;
    if ((state_q == cache_pkg::RF_DAT) && bus_rvalid_i) begin
      ln_fill_we_o[victim_q] = 1'b1;
    end
    if (state_q == cache_pkg::TAG_UPD) begin
      ln_tag_we_o[victim_q] = 1'b1;
    end
  end

  assign fill_done_o = (state_q == cache_pkg::TAG_UPD);

endmodule

`default_nettype wire

// ==== source/wb_cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_cache_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // processor side
  input  logic                         cpu_valid_i,
  input  logic                         cpu_we_i,
  input  logic [cache_pkg::ADDR_W-1:0]  cpu_addr_i,
  input  logic [cache_pkg::DATA_W-1:0]  cpu_wdata_i,
  input  logic [cache_pkg::STRB_W-1:0]  cpu_strb_i,
  output logic                         cpu_ready_o,
  output logic                         resp_valid_o,
  output logic [cache_pkg::DATA_W-1:0]  resp_rdata_o,
  // bus side
  output logic                         bus_avalid_o,
  output logic                         bus_awrite_o,
  output logic [cache_pkg::ADDR_W-1:0]  bus_addr_o,
  input  logic                         bus_aready_i,
  output logic                         bus_wvalid_o,
  output logic [cache_pkg::DATA_W-1:0]  bus_wdata_o,
  output logic                         bus_wlast_o,
  input  logic                         bus_wready_i,
  input  logic                         bus_rvalid_i,
  input  logic [cache_pkg::DATA_W-1:0]  bus_rdata_i,
  input  logic                         bus_rlast_i
);

  // access port
  cache_pkg::idx_t                                  acc_idx;
  cache_pkg::word_sel_t                             acc_word;
  logic [cache_pkg::WAY_CNT-1:0]                     acc_we;
  logic [cache_pkg::DATA_W-1:0]                      acc_wdata;
  logic [cache_pkg::STRB_W-1:0]                      acc_strb;
  cache_pkg::tag_t [cache_pkg::WAY_CNT-1:0]          acc_tag;
  logic [cache_pkg::WAY_CNT-1:0]                     acc_valid;
  logic [cache_pkg::WAY_CNT-1:0][cache_pkg::DATA_W-1:0] acc_rdata;

  // line port
  cache_pkg::idx_t                                  ln_idx;
  cache_pkg::word_sel_t                             ln_word;
  logic [cache_pkg::WAY_CNT-1:0]                     ln_fill_we;
  logic [cache_pkg::DATA_W-1:0]                      ln_fill_data;
  logic [cache_pkg::WAY_CNT-1:0]                     ln_tag_we;
  cache_pkg::tag_t                                  ln_tag;
  cache_pkg::tag_t [cache_pkg::WAY_CNT-1:0]          ln_tag_rd;
  logic [cache_pkg::WAY_CNT-1:0]                     ln_valid;
  logic [cache_pkg::WAY_CNT-1:0]                     ln_dirty;
  logic [cache_pkg::WAY_CNT-1:0][cache_pkg::DATA_W-1:0] ln_rdata;

  // miss handoff
  logic            miss_req;
  cache_pkg::idx_t miss_idx;
  cache_pkg::tag_t miss_tag;
  logic            fill_done;

  hit_access u_hit_access (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpu_valid_i  (cpu_valid_i),
    .cpu_we_i     (cpu_we_i),
    .cpu_addr_i   (cpu_addr_i),
    .cpu_wdata_i  (cpu_wdata_i),
    .cpu_strb_i   (cpu_strb_i),
    .cpu_ready_o  (cpu_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .way_tag_i    (acc_tag),
    .way_valid_i  (acc_valid),
    .way_rdata_i  (acc_rdata),
    .acc_idx_o    (acc_idx),
    .acc_word_o   (acc_word),
    .acc_we_o     (acc_we),
    .acc_wdata_o  (acc_wdata),
    .acc_strb_o   (acc_strb),
    .miss_req_o   (miss_req),
    .miss_idx_o   (miss_idx),
    .miss_tag_o   (miss_tag),
    .fill_done_i  (fill_done)
  );

  for (genvar w = 0; w < cache_pkg::WAY_CNT; w++) begin : g_way
    cache_way u_way (
      .clk            (clk),
      .rst_n          (rst_n),
      .acc_idx_i      (acc_idx),
      .acc_word_i     (acc_word),
      .acc_we_i       (acc_we[w]),
      .acc_wdata_i    (acc_wdata),
      .acc_strb_i     (acc_strb),
      .acc_tag_o      (acc_tag[w]),
      .acc_valid_o    (acc_valid[w]),
      .acc_rdata_o    (acc_rdata[w]),
      .ln_idx_i       (ln_idx),
      .ln_word_i      (ln_word),
      .ln_fill_we_i   (ln_fill_we[w]),
      .ln_fill_data_i (ln_fill_data),
      .ln_tag_we_i    (ln_tag_we[w]),
      .ln_tag_i       (ln_tag),
      .ln_tag_o       (ln_tag_rd[w]),
      .ln_valid_o     (ln_valid[w]),
      .ln_dirty_o     (ln_dirty[w]),
      .ln_rdata_o     (ln_rdata[w])
    );
  end

  line_refill_ctrl u_line_refill_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .miss_req_i     (miss_req),
    .miss_idx_i     (miss_idx),
    .miss_tag_i     (miss_tag),
    .fill_done_o    (fill_done),
    .ln_idx_o       (ln_idx),
    .ln_word_o      (ln_word),
    .ln_fill_we_o   (ln_fill_we),
    .ln_fill_data_o (ln_fill_data),
    .ln_tag_we_o    (ln_tag_we),
    .ln_tag_o       (ln_tag),
    .way_tag_i      (ln_tag_rd),
    .way_valid_i    (ln_valid),
    .way_dirty_i    (ln_dirty),
    .way_rdata_i    (ln_rdata),
    .bus_avalid_o   (bus_avalid_o),
    .bus_awrite_o   (bus_awrite_o),
    .bus_addr_o     (bus_addr_o),
    .bus_aready_i   (bus_aready_i),
    .bus_wvalid_o   (bus_wvalid_o),
    .bus_wdata_o    (bus_wdata_o),
    .bus_wlast_o    (bus_wlast_o),
    .bus_wready_i   (bus_wready_i),
    .bus_rvalid_i   (bus_rvalid_i),
    .bus_rdata_i    (bus_rdata_i),
    .bus_rlast_i    (bus_rlast_i)
  );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  // 100 ns period
  localparam int HALF_PERIOD = 50;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/tb_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cache;

  localparam int RESET_CYCLES = 8;
  localparam int VEC_MAX      = 64;
  localparam int VEC_COLS     = 6;
  localparam logic [31:0] NO_REQ = 32'hffff_ffff;

  logic        clk;
  logic        rst_n;
  logic        cpu_valid_i;
  logic        cpu_we_i;
  logic [31:0] cpu_addr_i;
  logic [31:0] cpu_wdata_i;
  logic [3:0]  cpu_strb_i;
  logic        cpu_ready_o;
  logic        resp_valid_o;
  logic [31:0] resp_rdata_o;
  logic        bus_avalid_o;
  logic        bus_awrite_o;
  logic [31:0] bus_addr_o;
  logic        bus_aready_i = 1'b0;
  logic        bus_wvalid_o;
  logic [31:0] bus_wdata_o;
  logic        bus_wlast_o;
  logic        bus_wready_i = 1'b0;
  logic        bus_rvalid_i = 1'b0;
  logic [31:0] bus_rdata_i  = 32'h0;
  logic        bus_rlast_i  = 1'b0;

  logic [31:0] vec_mem [0:511];
  int          n_req        = 0;
  int          limit_cycles = 0;
  int          cycle_cnt    = 0;
  int          err_cnt      = 0;

  // bus memory model state
  integer      seed = 32'hc944_47b9;
  int          bus_wait = 0;
  int          rd_left  = 0;
  int          wr_left  = 0;
  logic [31:0] rd_addr  = 32'h0;
  logic [31:0] wr_addr  = 32'h0;
  int          aphase_cnt = 0;
  bit          phase_write_q [$];
  logic [31:0] mem_words [logic [31:0]];

  tb_clock_gen #(.RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  wb_cache_top DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpu_valid_i  (cpu_valid_i),
    .cpu_we_i     (cpu_we_i),
    .cpu_addr_i   (cpu_addr_i),
    .cpu_wdata_i  (cpu_wdata_i),
    .cpu_strb_i   (cpu_strb_i),
    .cpu_ready_o  (cpu_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o),
    .bus_avalid_o (bus_avalid_o),
    .bus_awrite_o (bus_awrite_o),
    .bus_addr_o   (bus_addr_o),
    .bus_aready_i (bus_aready_i),
    .bus_wvalid_o (bus_wvalid_o),
    .bus_wdata_o  (bus_wdata_o),
    .bus_wlast_o  (bus_wlast_o),
    .bus_wready_i (bus_wready_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_rlast_i  (bus_rlast_i)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt = err_cnt + 1;
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] vec_word(input int req, input int col);
    return vec_mem[9'(req * VEC_COLS + col)];
  endfunction

  // never written words read back as their inverted address
  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (mem_words.exists(addr)) begin
      return mem_words[addr];
    end
    return ~addr;
  endfunction

  // bus memory waits 0 to 3 cycles before each transfer
  always @(negedge clk) begin
    bus_aready_i = 1'b0;
    bus_wready_i = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rlast_i  = 1'b0;
    if (!rst_n) begin
      rd_left  = 0;
      wr_left  = 0;
      bus_wait = $unsigned($random(seed)) % 4;
    end else if (rd_left > 0 || bus_avalid_o || bus_wvalid_o) begin
      if (bus_wait > 0) begin
        bus_wait = bus_wait - 1;
      end else begin
        bus_wait = $unsigned($random(seed)) % 4;
        if (rd_left > 0) begin
          bus_rvalid_i = 1'b1;
          bus_rdata_i  = mem_read(rd_addr);
          bus_rlast_i  = (rd_left == 1);
          rd_addr      = rd_addr + 4;
          rd_left      = rd_left - 1;
        end else if (bus_avalid_o) begin
          bus_aready_i = 1'b1;
          aphase_cnt   = aphase_cnt + 1;
          phase_write_q.push_back(bus_awrite_o);
          if (bus_awrite_o) begin
            wr_addr = bus_addr_o;
            wr_left = 4;
          end else begin
            rd_addr = bus_addr_o;
            rd_left = 4;
          end
        end else begin
          check_value("bus_wlast_o", 32'(bus_wlast_o), 32'(wr_left == 1));
          bus_wready_i        = 1'b1;
          mem_words[wr_addr]  = bus_wdata_o;
          wr_addr             = wr_addr + 4;
          wr_left             = wr_left - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (limit_cycles > 0 && cycle_cnt >= limit_cycles) begin
      $display("timeout after %0d cycles, the cache did not answer in time", cycle_cnt);
      $display("Something failed");
      $fatal(1);
    end
  end

  task automatic run_request(input int req);
    logic [31:0] op;
    logic [31:0] exp_rdata;
    int          exp_phases;
    int          start_cnt;
    int          latency;
    op         = vec_word(req, 0);
    exp_rdata  = vec_word(req, 4);
    exp_phases = vec_word(req, 5);
    start_cnt  = aphase_cnt;
    cpu_valid_i = 1'b1;
    cpu_we_i    = op[0];
    cpu_addr_i  = vec_word(req, 1);
    cpu_wdata_i = vec_word(req, 2);
    cpu_strb_i  = 4'(vec_word(req, 3));
    while (!cpu_ready_o) @(negedge clk);
    @(negedge clk);
    cpu_valid_i = 1'b0;
    latency = 1;
    while (!resp_valid_o) begin
      @(negedge clk);
      latency = latency + 1;
    end
    if (!op[0]) begin
      check_value("resp_rdata_o", resp_rdata_o, exp_rdata);
    end
    check_value("cpu_ready_o", 32'(cpu_ready_o), 32'd1);
    check_value("bus_avalid_o phases", aphase_cnt - start_cnt, exp_phases);
    // a hit answers in the second cycle after acceptance
    if (exp_phases == 0) begin
      check_value("resp_valid_o latency", latency, 32'd2);
    end
    if (exp_phases == 2) begin
      check_value("bus_awrite_o first phase", 32'(phase_write_q[start_cnt]), 32'd1);
      check_value("bus_awrite_o second phase", 32'(phase_write_q[start_cnt + 1]), 32'd0);
    end
  endtask

  initial begin
    cpu_valid_i = 1'b0;
    cpu_we_i    = 1'b0;
    cpu_addr_i  = 32'h0;
    cpu_wdata_i = 32'h0;
    cpu_strb_i  = 4'h0;
    for (int i = 0; i < 512; i++) begin
      vec_mem[9'(i)] = NO_REQ;
    end
    $readmemh("verification/cache_input.txt", vec_mem);
    while (n_req < VEC_MAX && vec_word(n_req, 0) != NO_REQ) begin
      n_req = n_req + 1;
    end
    if (n_req == 0) begin
      $display("no request could be read from verification/cache_input.txt");
      $display("Something failed");
      $fatal(1);
    end
    limit_cycles = n_req * 60 + RESET_CYCLES;
    @(posedge rst_n);
    @(negedge clk);
    check_value("cpu_ready_o", 32'(cpu_ready_o), 32'd1);
    check_value("resp_valid_o", 32'(resp_valid_o), 32'd0);
    check_value("bus_avalid_o", 32'(bus_avalid_o), 32'd0);
    check_value("bus_wvalid_o", 32'(bus_wvalid_o), 32'd0);
    for (int r = 0; r < n_req; r++) begin
      run_request(r);
    end
    @(negedge clk);
    if (err_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/cache_pkg.sv
source/cache_way.sv
source/hit_access.sv
source/line_refill_ctrl.sv
source/wb_cache_top.sv
verification/tb_clock_gen.sv
verification/tb_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="Something failed"

verilator --binary --timing -f vlog.f --top-module tb_cache -o sim_tb_cache
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb_cache > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
echo "simulation finished cleanly"
exit 0

// ==== verification/cache_input.txt ====
// op (0 read, 1 write) | address | write data | strobe | expected read data | bus address phases
// expected read data is ignored for writes
0 00001000 00000000 0 FFFFEFFF 1
0 00001008 00000000 0 FFFFEFF7 0
1 00001004 AABBCCDD 3 00000000 0
0 00001004 00000000 0 FFFFCCDD 0
0 00002000 00000000 0 FFFFDFFF 1
// dirty line 0x1000 goes out before the refill
0 00003000 00000000 0 FFFFCFFF 2
0 00001004 00000000 0 FFFFCCDD 1
0 00001008 00000000 0 FFFFEFF7 0
0 0000100C 00000000 0 FFFFEFF3 0
// write miss, refill then merge
1 00004050 12345678 C 00000000 1
0 00004050 00000000 0 1234BFAF 0
1 0000405C CAFEF00D F 00000000 0
0 0000405C 00000000 0 CAFEF00D 0
0 00005050 00000000 0 FFFFAFAF 1
0 00006054 00000000 0 FFFF9FAB 2
0 0000405C 00000000 0 CAFEF00D 1
0 00004050 00000000 0 1234BFAF 0
0 00004058 00000000 0 FFFFBFA7 0
1 000080A8 000000EE 1 00000000 1
0 000080A8 00000000 0 FFFF7FEE 0
1 00001000 0BADCAFE F 00000000 0
0 00001000 00000000 0 0BADCAFE 0
0 00007000 00000000 0 FFFF8FFF 2
0 00001000 00000000 0 0BADCAFE 1
0 00001004 00000000 0 FFFFCCDD 0
0 00007008 00000000 0 FFFF8FF7 0
0 12345670 00000000 0 EDCBA98F 1
0 1234567C 00000000 0 EDCBA983 0
